// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        cause_ebreak, cause_illegal, cause_misalign_fetch, cause_misalign_data
    } halt_cause_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_s;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_s;

    typedef union packed {
        inst_r_s r;
        inst_s_s s;   // Store and branch immediates
    } rv_inst_u;

    typedef struct packed {
        logic [xlen-1:0] op_a;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] imm;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        logic [2:0]      funct3;
        logic            use_imm;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            is_jal;
        logic            reg_we;
        logic            is_ebreak;
        logic            illegal;
    } dec_out_s;

    typedef struct packed {
        logic [xlen-1:0] alu_res;
        logic [xlen-1:0] rs2_data;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic            is_load;
        logic            is_store;
        logic            reg_we;
        logic [xlen-1:0] link;
        logic            is_jal;
    } exe_out_s;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [3:0]      mask;
        logic            rd_en;
        logic            wr_en;
    } dmem_req_s;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic            clk,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      a0_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    output logic [xlen-1:0] a0_data,
    input  logic            we,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [1:31];   // x0 not stored

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    assign a0_data  = (a0_addr == 5'd0) ? '0 : regs[a0_addr];

endmodule

`default_nettype wire

// File: hw/cpu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_decode import cpu_pkg::*; (
    input  rv_inst_u        inst,
    input  logic [xlen-1:0] pc,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output dec_out_s        dec
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    assign imm_i = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                    inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
    assign imm_u = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
    assign imm_j = {{11{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rs1, inst.r.funct3,
                    inst.r.rs2[0], inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

    always_comb begin
        dec          = '0;
        dec.op_a     = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rd       = inst.r.rd;
        dec.funct3   = inst.r.funct3;
        dec.alu_op   = alu_add;
        case (inst.r.opcode)
            op_lui: begin
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.alu_op  = alu_pass_b;
                dec.reg_we  = 1'b1;
            end
            op_imm: begin
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
                case (inst.r.funct3)
                    3'b000:  dec.alu_op = alu_add;
                    3'b010:  dec.alu_op = alu_slt;
                    3'b100:  dec.alu_op = alu_xor;
                    3'b110:  dec.alu_op = alu_or;
                    3'b111:  dec.alu_op = alu_and;
                    default: dec.illegal = 1'b1;   // No immediate shifts or sltiu
                endcase
            end
            op_reg: begin
                dec.reg_we = 1'b1;
                case ({inst.r.funct7, inst.r.funct3})
                    {7'h00, 3'b000}: dec.alu_op = alu_add;
                    {7'h20, 3'b000}: dec.alu_op = alu_sub;
                    {7'h00, 3'b001}: dec.alu_op = alu_sll;
                    {7'h00, 3'b010}: dec.alu_op = alu_slt;
                    {7'h00, 3'b100}: dec.alu_op = alu_xor;
                    {7'h00, 3'b101}: dec.alu_op = alu_srl;
                    {7'h00, 3'b110}: dec.alu_op = alu_or;
                    {7'h00, 3'b111}: dec.alu_op = alu_and;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            op_load: begin
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
                dec.reg_we  = 1'b1;
                dec.illegal = (inst.r.funct3 == 3'b011) || (inst.r.funct3[2:1] == 2'b11);
            end
            op_store: begin
                dec.imm      = imm_s;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.illegal  = (inst.s.funct3 > 3'b010);
            end
            op_branch: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.illegal   = (inst.s.funct3[2:1] != 2'b00);   // BEQ and BNE only
            end
            op_jal: begin
                dec.op_a    = pc;   // ALU also forms the jump target
                dec.imm     = imm_j;
                dec.use_imm = 1'b1;
                dec.is_jal  = 1'b1;
                dec.reg_we  = 1'b1;
            end
            op_system: begin
                dec.is_ebreak = (inst == 32'h0010_0073);
                dec.illegal   = (inst != 32'h0010_0073);
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_execute.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_execute import cpu_pkg::*; (
    input  dec_out_s        dec,
    input  logic [xlen-1:0] pc,
    output exe_out_s        exe,
    output logic [xlen-1:0] next_pc
);

    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic            taken;

    assign op_b = dec.use_imm ? dec.imm : dec.rs2_data;

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_res = dec.op_a + op_b;
            alu_sub:    alu_res = dec.op_a - op_b;
            alu_and:    alu_res = dec.op_a & op_b;
            alu_or:     alu_res = dec.op_a | op_b;
            alu_xor:    alu_res = dec.op_a ^ op_b;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(dec.op_a) < $signed(op_b)};
            alu_sll:    alu_res = dec.op_a << op_b[4:0];
            alu_srl:    alu_res = dec.op_a >> op_b[4:0];
            alu_pass_b: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // funct3[0] picks BNE over BEQ
    assign taken = dec.is_branch && ((dec.op_a == dec.rs2_data) ^ dec.funct3[0]);

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + dec.imm;
    assign next_pc   = taken      ? pc_target :
                       dec.is_jal ? alu_res : pc_plus4;

    always_comb begin
        exe          = '0;
        exe.alu_res  = alu_res;
        exe.rs2_data = dec.rs2_data;
        exe.rd       = dec.rd;
        exe.funct3   = dec.funct3;
        exe.is_load  = dec.is_load;
        exe.is_store = dec.is_store;
        exe.reg_we   = dec.reg_we;
        exe.link     = pc_plus4;
        exe.is_jal   = dec.is_jal;
    end

endmodule

`default_nettype wire

// File: hw/cpu_result.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_result import cpu_pkg::*; (
    input  exe_out_s        exe,
    output dmem_req_s       dmem_req,
    input  logic [xlen-1:0] dmem_rdata,
    output logic            misalign,
    output logic            wb_we,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [1:0]      byte_off;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] load_data;

    assign byte_off = exe.alu_res[1:0];

    always_comb begin
        dmem_req.addr  = exe.alu_res;
        dmem_req.rd_en = exe.is_load;
        dmem_req.wr_en = exe.is_store;
        case (exe.funct3[1:0])
            2'b00: begin
                dmem_req.mask  = 4'b0001 << byte_off;
                dmem_req.wdata = {4{exe.rs2_data[7:0]}};
            end
            2'b01: begin
                dmem_req.mask  = 4'b0011 << byte_off;
                dmem_req.wdata = {2{exe.rs2_data[15:0]}};
            end
            default: begin
                dmem_req.mask  = 4'b1111;
                dmem_req.wdata = exe.rs2_data;
            end
        endcase
    end

    assign misalign = (exe.is_load || exe.is_store) &&
                      ((exe.funct3[1:0] == 2'b01 && byte_off[0]) ||
                       (exe.funct3[1:0] == 2'b10 && byte_off != 2'b00));

    assign lane_data = dmem_rdata >> {byte_off, 3'b000};   // Addressed lane to bit 0

    always_comb begin
        case (exe.funct3)
            3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            3'b100:  load_data = {24'b0, lane_data[7:0]};
            3'b101:  load_data = {16'b0, lane_data[15:0]};
            default: load_data = lane_data;
        endcase
    end

    assign wb_we   = exe.reg_we;
    assign wb_rd   = exe.rd;
    assign wb_data = exe.is_jal  ? exe.link :
                     exe.is_load ? load_data : exe.alu_res;

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output dmem_req_s       dmem_req,
    input  logic [xlen-1:0] dmem_rdata,
    output logic            halted,
    output halt_cause_e     halt_cause,
    output logic [xlen-1:0] halt_pc,
    output logic [xlen-1:0] halt_a0
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    rv_inst_u        inst;
    dec_out_s        dec;
    exe_out_s        exe;
    dmem_req_s       res_req;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] a0_data;
    logic            misalign_fetch;
    logic            misalign_data;
    logic            trap;
    halt_cause_e     trap_cause;
    logic            wb_we;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;

    assign imem_addr = pc;
    assign inst      = imem_data;

    assign misalign_fetch = (pc[1:0] != 2'b00);
    assign trap = misalign_fetch || dec.illegal || misalign_data || dec.is_ebreak;
    assign trap_cause = misalign_fetch ? cause_misalign_fetch :
                        dec.illegal    ? cause_illegal :
                        misalign_data  ? cause_misalign_data : cause_ebreak;

    always_comb begin
        dmem_req       = res_req;
        dmem_req.wr_en = res_req.wr_en && !trap && !halted;
    end

    cpu_decode u_decode (.inst(inst), .pc(pc), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
                         .rs1_data(rs1_data), .rs2_data(rs2_data), .dec(dec));

    cpu_execute u_execute (.dec(dec), .pc(pc), .exe(exe), .next_pc(next_pc));

    cpu_result u_result (.exe(exe), .dmem_req(res_req), .dmem_rdata(dmem_rdata),
                         .misalign(misalign_data), .wb_we(wb_we), .wb_rd(wb_rd),
                         .wb_data(wb_data));

    reg_file u_regs (.clk(clk), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .a0_addr(5'd10),
                     .rs1_data(rs1_data), .rs2_data(rs2_data), .a0_data(a0_data),
                     .we(wb_we && !trap && !halted), .rd(wb_rd), .wdata(wb_data));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= '0;
            halted     <= 1'b0;
            halt_cause <= cause_ebreak;
            halt_pc    <= '0;
            halt_a0    <= '0;
        end else if (!halted) begin
            if (trap) begin
                halted     <= 1'b1;
                halt_cause <= trap_cause;
                halt_pc    <= pc;
                halt_a0    <= a0_data;   // a0 before this instruction
            end else begin
                pc <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl import cpu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic            clk,
    input  logic [xlen-1:0] imem_addr,
    output logic [xlen-1:0] imem_data,
    input  dmem_req_s       dmem_req,
    output logic [xlen-1:0] dmem_rdata,
    input  logic            prog_we,
    input  logic [xlen-1:0] prog_addr,
    input  logic [xlen-1:0] prog_data
);

    localparam int aw = $clog2(mem_words);

    logic [xlen-1:0] mem [mem_words];
    logic [aw-1:0]   i_idx;
    logic [aw-1:0]   d_idx;
    logic [aw-1:0]   p_idx;

    // Word indices wrap at the array size
    assign i_idx = imem_addr[aw+1:2];
    assign d_idx = dmem_req.addr[aw+1:2];
    assign p_idx = prog_addr[aw-1:0];

    assign imem_data  = mem[i_idx];
    assign dmem_rdata = dmem_req.rd_en ? mem[d_idx] : '0;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[p_idx] <= prog_data;   // Program load wins
        end else if (dmem_req.wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.mask[i]) begin
                    mem[d_idx][i*8 +: 8] <= dmem_req.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            prog_we,
    input  logic [xlen-1:0] prog_addr,
    input  logic [xlen-1:0] prog_data,
    output logic            halted,
    output halt_cause_e     halt_cause,
    output logic [xlen-1:0] halt_pc,
    output logic [xlen-1:0] halt_a0
);

    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_data;
    dmem_req_s       dmem_req;
    logic [xlen-1:0] dmem_rdata;

    cpu_core u_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .halted    (halted),
        .halt_cause(halt_cause),
        .halt_pc   (halt_pc),
        .halt_a0   (halt_a0)
    );

    mem_ctrl #(.mem_words(mem_words)) u_mem (
        .clk       (clk),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;   // 50 percent duty
    end

endmodule

`default_nettype wire

// File: verification/cpu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_asserts import cpu_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic            halted,
    input logic            trap,
    input logic [xlen-1:0] pc,
    input dec_out_s        dec,
    input dmem_req_s       dmem_req
);

    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else $error("halted dropped while reset was inactive");

    a_no_store_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !dmem_req.wr_en)
        else $error("data write enable high while halted");

    // Straight-line instructions step by one word
    a_pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        (!halted && !trap && !dec.is_branch && !dec.is_jal) |=> pc == $past(pc) + 32'd4)
        else $error("pc did not advance by 4");

endmodule

bind cpu_core cpu_asserts u_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .halted  (halted),
    .trap    (trap),
    .pc      (pc),
    .dec     (dec),
    .dmem_req(dmem_req)
);

`default_nettype wire

// File: verification/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int n_entries    = 8;
    localparam int prog_len     = 6;
    localparam int halt_timeout = 200;

    localparam logic [4:0] x0 = 5'd0;
    localparam logic [4:0] t0 = 5'd5;
    localparam logic [4:0] t1 = 5'd6;
    localparam logic [4:0] t2 = 5'd7;
    localparam logic [4:0] t3 = 5'd28;
    localparam logic [4:0] a0 = 5'd10;

    logic            clk;
    logic            arst_n;
    logic            prog_we;
    logic [31:0]     prog_addr;
    logic [31:0]     prog_data;
    logic            halted;
    halt_cause_e     halt_cause;
    logic [31:0]     halt_pc;
    logic [31:0]     halt_a0;

    logic [31:0]     prog_tab [n_entries][prog_len];
    halt_cause_e     exp_cause [n_entries];
    logic [31:0]     exp_pc [n_entries];
    logic [31:0]     exp_a0 [n_entries];
    logic [31:0]     rng_state;

    tb_clk_gen #(.period(20)) u_clk (.clk(clk));

    cpu_top #(.mem_words(256)) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .halt_cause(halt_cause),
        .halt_pc   (halt_pc),
        .halt_a0   (halt_a0)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [11:0] next_imm12();
        rng_state = xorshift32(rng_state);
        return rng_state[11:0];
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] sext8(input logic [7:0] v);
        return {{24{v[7]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic set_result(input int idx, input halt_cause_e cause,
                              input logic [31:0] pc, input logic [31:0] a0_val);
        exp_cause[idx] = cause;
        exp_pc[idx]    = pc;
        exp_a0[idx]    = a0_val;
    endtask

    task automatic build_table();
        logic [11:0] imm;
        logic [31:0] ebreak_w;
        logic [31:0] r1;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] word;
        for (int e = 0; e < n_entries; e++) begin
            for (int i = 0; i < prog_len; i++) begin
                prog_tab[e][i] = 32'h0;   // Unused slots hold an illegal word
            end
        end
        ebreak_w = enc_i(12'd1, x0, 3'b000, x0, op_system);

        imm = next_imm12();   // Arithmetic chain
        r1  = sext12(imm);
        prog_tab[0][0] = enc_i(imm, x0, 3'b000, t0, op_imm);
        prog_tab[0][1] = enc_r(7'h00, t0, t0, 3'b000, t1);   // add t1, t0, t0
        prog_tab[0][2] = enc_r(7'h00, t0, t1, 3'b100, t2);   // xor t2, t1, t0
        prog_tab[0][3] = enc_r(7'h00, t0, t2, 3'b010, t3);   // slt t3, t2, t0
        prog_tab[0][4] = enc_r(7'h20, t3, t2, 3'b000, a0);   // sub a0, t2, t3
        prog_tab[0][5] = ebreak_w;
        v1 = r1 + r1;
        v2 = v1 ^ r1;
        v3 = ($signed(v2) < $signed(r1)) ? 32'd1 : 32'd0;
        set_result(0, cause_ebreak, 32'd20, v2 - v3);

        prog_tab[1][0] = enc_i(12'hf80, x0, 3'b000, t0, op_imm);   // t0 = -128
        prog_tab[1][1] = enc_s(12'h100, t0, x0, 3'b010);
        prog_tab[1][2] = enc_s(12'h102, t0, x0, 3'b001);           // Upper half lane
        prog_tab[1][3] = enc_s(12'h101, x0, x0, 3'b000);           // Zero byte 1
        prog_tab[1][4] = enc_i(12'h100, x0, 3'b010, a0, op_load);
        prog_tab[1][5] = ebreak_w;
        word        = sext12(12'hf80);
        word[31:16] = word[15:0];
        word[15:8]  = 8'h00;
        set_result(1, cause_ebreak, 32'd20, word);

        prog_tab[2][0] = enc_i(12'h102, x0, 3'b001, t0, op_load);   // lh
        prog_tab[2][1] = enc_i(12'h100, x0, 3'b100, t1, op_load);   // lbu
        prog_tab[2][2] = enc_i(12'h100, x0, 3'b000, t2, op_load);   // lb
        prog_tab[2][3] = enc_r(7'h20, t1, t2, 3'b000, t3);
        prog_tab[2][4] = enc_r(7'h00, t0, t3, 3'b100, a0);
        prog_tab[2][5] = ebreak_w;
        v1 = sext16(word[31:16]);
        v2 = {24'h0, word[7:0]};
        v3 = sext8(word[7:0]);
        set_result(2, cause_ebreak, 32'd20, (v3 - v2) ^ v1);

        prog_tab[3][0] = enc_b(13'd8, x0, x0, 3'b000);   // beq over the illegal word
        prog_tab[3][2] = enc_b(13'd8, x0, x0, 3'b001);   // bne falls through
        prog_tab[3][3] = enc_j(21'd4, t0);
        prog_tab[3][4] = enc_i(12'h000, t0, 3'b000, a0, op_imm);
        prog_tab[3][5] = ebreak_w;
        set_result(3, cause_ebreak, 32'd20, 32'd12 + 32'd4);

        imm = next_imm12();
        prog_tab[4][0] = enc_i(imm, x0, 3'b000, a0, op_imm);
        set_result(4, cause_illegal, 32'd4, sext12(imm));

        prog_tab[5][0] = enc_i(12'd7, x0, 3'b000, a0, op_imm);
        prog_tab[5][1] = enc_s(12'h101, a0, x0, 3'b001);   // sh to odd address
        prog_tab[5][2] = ebreak_w;
        set_result(5, cause_misalign_data, 32'd4, 32'd7);

        prog_tab[6][0] = enc_i(12'h100, x0, 3'b010, a0, op_load);
        prog_tab[6][1] = enc_i(12'h102, x0, 3'b010, t0, op_load);   // lw at offset 2
        prog_tab[6][2] = ebreak_w;
        set_result(6, cause_misalign_data, 32'd4, word);

        // The jal completes, the fetch at its target traps
        prog_tab[7][0] = enc_i(12'h055, x0, 3'b000, a0, op_imm);
        prog_tab[7][1] = enc_j(21'd6, a0);
        prog_tab[7][2] = ebreak_w;
        set_result(7, cause_misalign_fetch, 32'd4 + 32'd6, 32'd4 + 32'd4);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic run_entry(input int idx);
        int cycles;
        for (int i = 0; i < prog_len; i++) begin   // Core is halted or in reset here
            @(posedge clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = i;
            prog_data = prog_tab[idx][i];
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
        arst_n  = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < halt_timeout) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!halted) begin
            $display("Core did not halt within %0d cycles in entry %0d", halt_timeout, idx);
            $display("=== FAIL ===");
            $fatal(1, "halt timeout");
        end
        check_value($sformatf("entry %0d halt_cause", idx), {30'd0, halt_cause},
                    {30'd0, exp_cause[idx]});
        check_value($sformatf("entry %0d halt_pc", idx), halt_pc, exp_pc[idx]);
        check_value($sformatf("entry %0d halt_a0", idx), halt_a0, exp_a0[idx]);
    endtask

    initial begin
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 32'h0;
        prog_data = 32'h0;
        rng_state = 32'd68;
        build_table();
        for (int e = 0; e < n_entries; e++) begin
            run_entry(e);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_result.sv
hw/cpu_core.sv
hw/mem_ctrl.sv
hw/cpu_top.sv
verification/tb_clk_gen.sv
verification/cpu_asserts.sv
verification/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
